//--- source/cpc_boot_pkg.sv
// Download index values follow the host menu order and the boot space is one 8 MB bank
package cpc_boot_pkg;

	parameter int BOOT_ADDR_W = 23;
	parameter int PAGE_W      = 9;

	typedef logic [BOOT_ADDR_W-1:0] boot_addr_t; // Bit 22 picks the high ROM half
	typedef logic [PAGE_W-1:0]      rom_page_t;  // Half bit on top of an 8 bit page

	typedef enum logic [1:0] {DL_NONE, DL_ROM, DL_EXT} dl_kind_e;
	typedef enum logic [1:0] {REGION_OS, REGION_BASIC, REGION_AMSDOS, REGION_MF2} rom_region_e;

	localparam logic [7:0] IDX_ROM = 8'd0;
	localparam logic [7:0] IDX_EXT = 8'd3;

	// Page bases of the system ROM regions
	localparam rom_page_t PAGE_OS        = 9'h000;
	localparam rom_page_t PAGE_BASIC     = 9'h100;
	localparam rom_page_t PAGE_AMSDOS    = 9'h107;
	localparam rom_page_t PAGE_MF2       = 9'h0FF;
	localparam rom_page_t PAGE_MALFORMED = 9'h1EE; // Unused page for bad extensions
	localparam rom_page_t PAGE_COMBO_END = 9'h1FF;

	typedef struct packed {
		logic        wr;
		logic        download;
		logic [7:0]  index;
		logic [24:0] addr;
		logic [7:0]  dout;
		logic [15:0] file_ext; // Two ASCII characters
	} ioctl_t;

	typedef struct packed {
		logic       wr;
		boot_addr_t addr;
		logic [1:0] bank;
		logic [7:0] dout;
	} boot_wr_t;

	function automatic dl_kind_e dl_kind(input ioctl_t io);
		dl_kind_e kind;
		kind = DL_NONE;
		if (io.download && io.index == IDX_ROM)
			kind = DL_ROM;
		else if (io.download && io.index == IDX_EXT)
			kind = DL_EXT;
		return kind;
	endfunction

endpackage

//--- source/mf2_pkg.sv
// Store addresses match the Multiface Two firmware layout of its 8 KB RAM
package mf2_pkg;

	parameter int MF2_RAM_WORDS = 8192;
	parameter int MF2_ADDR_W    = 13;

	typedef struct packed {
		logic [15:0] addr;
		logic [7:0]  dout;
		logic        m1;
		logic        io_wr;
		logic        mem_wr;
		logic        mem_rd;
	} cpu_bus_t;

	typedef enum logic [1:0] {MF2_ENABLED = 2'd0, MF2_HIDDEN = 2'd1, MF2_DISABLED = 2'd2} mf2_mode_e;

	typedef enum logic [3:0] {
		PORT_PEN, PORT_COLOUR, PORT_MODE, PORT_BANK, PORT_CRTC_SEL,
		PORT_CRTC_VAL, PORT_PPI, PORT_UPPER_ROM, PORT_NONE
	} mf2_port_e;

	////////////////////
	// CPU side decode
	localparam logic [15:0] MF2_PORT_ON  = 16'hFEE8; // FEEA turns it off
	localparam logic [15:0] NMI_ENTRY    = 16'h0066;
	localparam logic [15:0] NMI_HIDE     = 16'h0065;
	localparam logic [2:0]  WIN_ROM      = 3'b000; // 0000 to 1FFF
	localparam logic [2:0]  WIN_RAM      = 3'b001; // 2000 to 3FFF

	////////////////////
	// Shadow store locations
	localparam logic [MF2_ADDR_W-1:0] ST_PEN_INDEX = 13'h1FCF;
	localparam logic [MF2_ADDR_W-1:0] ST_PEN_BASE  = 13'h1F90;
	localparam logic [MF2_ADDR_W-1:0] ST_BORDER    = 13'h1FDF;
	localparam logic [MF2_ADDR_W-1:0] ST_MODE      = 13'h1FEF;
	localparam logic [MF2_ADDR_W-1:0] ST_BANK      = 13'h1FFF;
	localparam logic [MF2_ADDR_W-1:0] ST_CRTC_SEL  = 13'h1CFF;
	localparam logic [MF2_ADDR_W-1:0] ST_CRTC_BASE = 13'h1DB0;
	localparam logic [MF2_ADDR_W-1:0] ST_PPI       = 13'h17FF;
	localparam logic [MF2_ADDR_W-1:0] ST_UPPER_ROM = 13'h1AAC;

endpackage

//--- source/page_config.sv
// Extension must be upper case hex ASCII and is decoded only on the edge a download starts
`timescale 1ns/10ps

module page_config import cpc_boot_pkg::*; (
	input  logic      clk_sys,
	input  logic      reset,
	input  logic      cpc664,
	input  ioctl_t    ioctl,
	input  logic      combo_done,
	output rom_page_t page,
	output logic      combo_active,
	output logic      model
);

	logic     old_download;
	logic     ext_start;
	logic [4:0] digit_hi; // Valid flag over nibble
	logic [4:0] digit_lo;

	// Hex character to nibble
	function automatic logic [4:0] hex_digit(input logic [7:0] c);
		logic [4:0] res;
		res = '0;
		if (c >= "0" && c <= "9")
			res = {1'b1, c[3:0]};
		else if (c >= "A" && c <= "F")
			res = {1'b1, c[3:0] + 4'd9};
		return res;
	endfunction

	assign digit_hi  = hex_digit(ioctl.file_ext[15:8]);
	assign digit_lo  = hex_digit(ioctl.file_ext[7:0]);
	assign ext_start = ~old_download & ioctl.download & (dl_kind(ioctl) == DL_EXT);

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			old_download <= 1'b0;
			page         <= '0;
			combo_active <= 1'b0;
			model        <= cpc664; // Tracks the setting for as long as reset is held
		end else begin
			old_download <= ioctl.download;
			if (combo_done) begin
				page         <= PAGE_COMBO_END;
				combo_active <= 1'b0;
			end
			if (ext_start) begin
				page         <= PAGE_MALFORMED;
				combo_active <= 1'b0;
				if (digit_hi[4]) page[7:4] <= digit_hi[3:0];
				if (digit_lo[4]) page[3:0] <= digit_lo[3:0];
				if (ioctl.file_ext == "ZZ")
					page <= '0;
				if (ioctl.file_ext == "Z0") begin
					page         <= '0;
					combo_active <= 1'b1; // Runs on into page 1FF
				end
			end
		end
	end

endmodule

//--- source/rom_loader.sv
// Boot writes are combinational from ioctl and ROM download blocks past 7 are dropped
`timescale 1ns/10ps

module rom_loader import cpc_boot_pkg::*; #(
	parameter int ROM_MAP_PAGES = 256
) (
	input  logic                     clk_sys,
	input  logic                     reset,
	input  ioctl_t                   ioctl,
	input  rom_page_t                page,
	input  logic                     combo_active,
	input  logic                     model,
	output boot_wr_t                 boot,
	output logic [ROM_MAP_PAGES-1:0] rom_map,
	output logic                     combo_done
);

	localparam int MAP_IDX_W = $clog2(ROM_MAP_PAGES);

	dl_kind_e    kind;
	logic [10:0] block;       // 16 KB block of the download
	rom_region_e region;
	rom_page_t   region_page;
	logic        wr_ok;       // Address maps somewhere valid
	logic        old_wr;
	logic        wr_done;

	assign kind   = dl_kind(ioctl);
	assign block  = ioctl.addr[24:14];
	assign region = rom_region_e'(block[1:0]);

	always_comb begin
		case (region)
			REGION_OS:     region_page = PAGE_OS;
			REGION_BASIC:  region_page = PAGE_BASIC;
			REGION_AMSDOS: region_page = PAGE_AMSDOS;
			default:       region_page = PAGE_MF2;
		endcase
	end

	////////////////////
	// Address and bank mapping
	// Low 4 MB holds OS, RAM pages and MF2 ROM, high 4 MB up to 256 ROM pages
	always_comb begin
		wr_ok             = 1'b0;
		boot.addr[13:0]   = ioctl.addr[13:0];
		boot.addr[22:14]  = '1;
		boot.bank         = 2'b00;
		boot.dout         = ioctl.dout;
		case (kind)
			DL_EXT: begin
				wr_ok             = 1'b1;
				boot.addr[22]     = page[8];
				boot.addr[21:14]  = page[7:0] + ioctl.addr[21:14];
				boot.bank         = {1'b0, model};
			end
			DL_ROM: begin
				if (block < 11'd8) begin
					wr_ok            = 1'b1;
					boot.addr[22:14] = region_page;
					boot.bank        = {1'b0, block[2]}; // Second set for the 664
				end
			end
			default: wr_ok = 1'b0;
		endcase
		boot.wr = wr_ok & ioctl.wr;
	end

	////////////////////
	// Completed writes
	assign wr_done    = wr_ok & old_wr & ~ioctl.wr;
	assign combo_done = wr_done & combo_active & (&boot.addr[13:0]); // Last byte of a page

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			old_wr  <= 1'b0;
			rom_map <= '0;
		end else begin
			old_wr <= ioctl.wr;
			if (wr_done && boot.addr[22])
				rom_map[boot.addr[14 +: MAP_IDX_W]] <= 1'b1;
		end
	end

endmodule

//--- source/mf2_control.sv
// All bus strobes are level inputs and only their rising edges act on the paging state
`timescale 1ns/10ps

module mf2_control import mf2_pkg::*; (
	input  logic      clk_sys,
	input  logic      reset,
	input  cpu_bus_t  bus,
	input  logic      key_nmi,
	input  mf2_mode_e mf2_mode,
	output logic      mf2_nmi,
	output logic      mf2_en,
	output logic      rom_en,
	output logic      ram_en,
	output logic      shadow_wr
);

	logic old_key_nmi;
	logic old_m1;
	logic old_io_wr;
	logic hidden;
	logic key_rise;
	logic m1_rise;
	logic io_rise;
	logic port_hit;  // FEE8 or FEEA
	logic disabled;

	assign key_rise = key_nmi & ~old_key_nmi;
	assign m1_rise  = bus.m1 & ~old_m1;
	assign io_rise  = bus.io_wr & ~old_io_wr;
	assign port_hit = bus.addr[15:2] == MF2_PORT_ON[15:2];
	assign disabled = mf2_mode == MF2_DISABLED;

	assign shadow_wr = io_rise & ~port_hit;
	assign rom_en    = mf2_en & (bus.addr[15:13] == WIN_ROM);
	assign ram_en    = mf2_en & (bus.addr[15:13] == WIN_RAM);

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			old_key_nmi <= 1'b0;
			old_m1      <= 1'b0;
			old_io_wr   <= 1'b0;
			mf2_nmi     <= 1'b0;
			mf2_en      <= 1'b0;
			hidden      <= mf2_mode != MF2_ENABLED;
		end else begin
			old_key_nmi <= key_nmi;
			old_m1      <= bus.m1;
			old_io_wr   <= bus.io_wr;
			if (key_rise && !mf2_en && !disabled)
				mf2_nmi <= 1'b1;
			if (m1_rise && mf2_nmi && bus.addr == NMI_ENTRY) begin // NMI vector fetch
				mf2_en  <= 1'b1;
				hidden  <= 1'b0;
				mf2_nmi <= 1'b0;
			end
			if (m1_rise && mf2_en && bus.addr == NMI_HIDE)
				hidden <= 1'b1;
			if (io_rise && port_hit)
				mf2_en <= ~bus.addr[1] & ~hidden & ~disabled; // FEEA pages out
		end
	end

endmodule

//--- source/mf2_shadow.sv
// Reads need a steady address with mem_rd for two clocks and shadow stores win over CPU writes
`timescale 1ns/10ps

module mf2_shadow import mf2_pkg::*; (
	input  logic       clk_sys,
	input  logic       reset,
	input  cpu_bus_t   bus,
	input  logic       shadow_wr,
	input  logic       ram_en,
	output logic [7:0] mf2_dout
);

	mf2_port_e             port;
	logic [MF2_ADDR_W-1:0] store_addr;
	logic                  store;
	logic [4:0]            pen_index;
	logic [3:0]            crtc_reg;
	logic [MF2_ADDR_W-1:0] ram_a;
	logic [7:0]            ram_in;
	logic                  ram_we;
	logic [7:0]            ram_out;
	logic [7:0]            ram [MF2_RAM_WORDS];

	////////////////////
	// Port decode
	always_comb begin
		case (bus.addr[15:8])
			8'h7F: begin
				case (bus.dout[7:6]) // Gate array function
					2'b00:   port = PORT_PEN;
					2'b01:   port = PORT_COLOUR;
					2'b10:   port = PORT_MODE;
					default: port = PORT_BANK;
				endcase
			end
			8'hBC:   port = PORT_CRTC_SEL;
			8'hBD:   port = PORT_CRTC_VAL;
			8'hF7:   port = PORT_PPI;
			8'hDF:   port = PORT_UPPER_ROM;
			default: port = PORT_NONE;
		endcase
	end

	always_comb begin
		case (port)
			PORT_PEN:       store_addr = ST_PEN_INDEX;
			PORT_COLOUR:    store_addr = pen_index[4] ? ST_BORDER : ST_PEN_BASE + pen_index[3:0];
			PORT_MODE:      store_addr = ST_MODE;
			PORT_BANK:      store_addr = ST_BANK;
			PORT_CRTC_SEL:  store_addr = ST_CRTC_SEL;
			PORT_CRTC_VAL:  store_addr = ST_CRTC_BASE + crtc_reg;
			PORT_PPI:       store_addr = ST_PPI;
			PORT_UPPER_ROM: store_addr = ST_UPPER_ROM;
			default:        store_addr = '0;
		endcase
	end

	assign store = shadow_wr & (port != PORT_NONE);

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			ram_we    <= 1'b0;
			pen_index <= '0;
			crtc_reg  <= '0;
		end else begin
			ram_we <= store | (bus.mem_wr & ram_en);
			if (store && port == PORT_PEN)
				pen_index <= bus.dout[4:0];
			if (store && port == PORT_CRTC_SEL)
				crtc_reg <= bus.dout[3:0];
		end
	end

	// RAM port address and data
	always_ff @(posedge clk_sys) begin
		ram_a  <= store ? store_addr : bus.addr[MF2_ADDR_W-1:0];
		ram_in <= bus.dout;
	end

	////////////////////
	// 8 KB MF2 RAM
	always_ff @(posedge clk_sys) begin
		if (ram_we) begin
			ram[ram_a] <= ram_in;
			ram_out    <= ram_in;
		end else begin
			ram_out <= ram[ram_a];
		end
	end

	assign mf2_dout = (ram_en & bus.mem_rd) ? ram_out : 8'hFF; // Open bus otherwise

endmodule

//--- source/cpc_expansion_top.sv
// Loader and Multiface Two halves share only the clock and reset
`timescale 1ns/10ps

module cpc_expansion_top import cpc_boot_pkg::*, mf2_pkg::*; #(
	parameter int ROM_MAP_PAGES = 256
) (
	input  logic                     clk_sys,
	input  logic                     reset,
	input  ioctl_t                   ioctl,
	input  logic                     cpc664,
	output boot_wr_t                 boot,
	output logic [ROM_MAP_PAGES-1:0] rom_map,
	input  cpu_bus_t                 bus,
	input  logic                     key_nmi,
	input  mf2_mode_e                mf2_mode,
	output logic                     mf2_nmi,
	output logic                     mf2_en,
	output logic                     rom_en,
	output logic                     ram_en,
	output logic [7:0]               mf2_dout
);

	rom_page_t page;
	logic      combo_active;
	logic      combo_done;
	logic      model;
	logic      shadow_wr;

	////////////////////
	// Boot loader
	page_config u_page_config (
		.clk_sys      (clk_sys),
		.reset        (reset),
		.cpc664       (cpc664),
		.ioctl        (ioctl),
		.combo_done   (combo_done),
		.page         (page),
		.combo_active (combo_active),
		.model        (model)
	);

	rom_loader #(.ROM_MAP_PAGES(ROM_MAP_PAGES)) u_rom_loader (
		.clk_sys      (clk_sys),
		.reset        (reset),
		.ioctl        (ioctl),
		.page         (page),
		.combo_active (combo_active),
		.model        (model),
		.boot         (boot),
		.rom_map      (rom_map),
		.combo_done   (combo_done)
	);

	////////////////////
	// Multiface Two
	mf2_control u_mf2_control (
		.clk_sys   (clk_sys),
		.reset     (reset),
		.bus       (bus),
		.key_nmi   (key_nmi),
		.mf2_mode  (mf2_mode),
		.mf2_nmi   (mf2_nmi),
		.mf2_en    (mf2_en),
		.rom_en    (rom_en),
		.ram_en    (ram_en),
		.shadow_wr (shadow_wr)
	);

	mf2_shadow u_mf2_shadow (
		.clk_sys   (clk_sys),
		.reset     (reset),
		.bus       (bus),
		.shadow_wr (shadow_wr),
		.ram_en    (ram_en),
		.mf2_dout  (mf2_dout)
	);

endmodule

//--- test/tb_vectors.svh
// Must be included inside the testbench module after the package imports
`ifndef TB_VECTORS_SVH
`define TB_VECTORS_SVH

localparam int N_ROM    = 9;
localparam int N_EXT    = 4;
localparam int N_MF2    = 10;
localparam int N_SHADOW = 7;

// Block, expected page base, bank, write
typedef struct packed {
	logic [10:0] block;
	rom_page_t   page;
	logic [1:0]  bank;
	logic        wr;
} rom_row_t;

// Extension, block inside the file, expected page
typedef struct packed {
	logic [15:0] ext;
	logic [7:0]  block;
	rom_page_t   page;
} ext_row_t;

typedef enum logic [1:0] {OP_KEY, OP_M1, OP_IOW} op_e;

// Strobe, mode, address, expected mf2_nmi and mf2_en afterwards
typedef struct packed {
	op_e         op;
	mf2_mode_e   mode;
	logic [15:0] addr;
	logic        nmi;
	logic        en;
} mf2_row_t;

// Port high byte, data, random data flag, expected store address
typedef struct packed {
	logic [7:0]            port;
	logic [7:0]            data;
	logic                  rnd;
	logic [MF2_ADDR_W-1:0] store;
} shadow_row_t;

localparam rom_row_t ROM_ROWS [N_ROM] = '{
	'{11'd0, 9'h000, 2'd0, 1'b1}, '{11'd1, 9'h100, 2'd0, 1'b1}, '{11'd2, 9'h107, 2'd0, 1'b1},
	'{11'd3, 9'h0FF, 2'd0, 1'b1}, '{11'd4, 9'h000, 2'd1, 1'b1}, '{11'd5, 9'h100, 2'd1, 1'b1},
	'{11'd6, 9'h107, 2'd1, 1'b1}, '{11'd7, 9'h0FF, 2'd1, 1'b1}, '{11'd8, 9'h000, 2'd0, 1'b0}
};

localparam ext_row_t EXT_ROWS [N_EXT] = '{
	'{"3A", 8'd0, 9'h13A}, '{"0F", 8'd2, 9'h10F}, '{"Q1", 8'd1, 9'h1E1}, '{"ZZ", 8'd0, 9'h000}
};

localparam mf2_row_t MF2_ROWS [N_MF2] = '{
	'{OP_KEY, MF2_ENABLED, 16'h0000, 1'b1, 1'b0}, '{OP_M1, MF2_ENABLED, 16'h0066, 1'b0, 1'b1},
	'{OP_IOW, MF2_ENABLED, 16'hFEEA, 1'b0, 1'b0}, '{OP_KEY, MF2_ENABLED, 16'h0000, 1'b1, 1'b0},
	'{OP_M1, MF2_ENABLED, 16'h0066, 1'b0, 1'b1}, '{OP_M1, MF2_ENABLED, 16'h0065, 1'b0, 1'b1},
	'{OP_IOW, MF2_ENABLED, 16'hFEEA, 1'b0, 1'b0}, '{OP_IOW, MF2_ENABLED, 16'hFEE8, 1'b0, 1'b0},
	'{OP_KEY, MF2_DISABLED, 16'h0000, 1'b0, 1'b0}, '{OP_IOW, MF2_DISABLED, 16'hFEE8, 1'b0, 1'b0}
};

localparam shadow_row_t SHADOW_ROWS [N_SHADOW] = '{
	'{8'h7F, 8'h03, 1'b0, 13'h1FCF}, '{8'h7F, 8'h55, 1'b0, 13'h1F93}, // Pen 3 and its colour
	'{8'h7F, 8'h10, 1'b0, 13'h1FCF}, '{8'h7F, 8'h4B, 1'b0, 13'h1FDF}, // Border
	'{8'hBC, 8'h0C, 1'b0, 13'h1CFF}, '{8'hBD, 8'h00, 1'b1, 13'h1DBC},
	'{8'hF7, 8'h00, 1'b1, 13'h17FF}
};

`endif

//--- test/tb_cpc_expansion.sv
// Assumes the default 256 page ROM map and stops at the first mismatch or at the cycle limit
`timescale 1ns/10ps

module tb_cpc_expansion import cpc_boot_pkg::*, mf2_pkg::*; ();

	localparam int MAP_PAGES = 256;

	`include "tb_vectors.svh"

	localparam int ROW_COUNT      = N_ROM + N_EXT + 2 + N_MF2 + N_SHADOW; // 2 combo writes
	localparam int TIMEOUT_CYCLES = ROW_COUNT * 8 + 50;

	logic                 clk_sys;
	logic                 reset;
	ioctl_t               ioctl;
	logic                 cpc664;
	boot_wr_t             boot;
	logic [MAP_PAGES-1:0] rom_map;
	cpu_bus_t             bus;
	logic                 key_nmi;
	mf2_mode_e            mf2_mode;
	logic                 mf2_nmi;
	logic                 mf2_en;
	logic                 rom_en;
	logic                 ram_en;
	logic [7:0]           mf2_dout;

	integer               seed;
	int                   cycle_count = 0;
	logic [MAP_PAGES-1:0] exp_map;
	logic [7:0]           exp_ram [MF2_RAM_WORDS]; // Last byte stored per MF2 address

	cpc_expansion_top #(.ROM_MAP_PAGES(MAP_PAGES)) UUT (
		.clk_sys (clk_sys), .reset (reset), .ioctl (ioctl), .cpc664 (cpc664),
		.boot (boot), .rom_map (rom_map), .bus (bus), .key_nmi (key_nmi),
		.mf2_mode (mf2_mode), .mf2_nmi (mf2_nmi), .mf2_en (mf2_en),
		.rom_en (rom_en), .ram_en (ram_en), .mf2_dout (mf2_dout)
	);

	initial clk_sys = 1'b0;
	always #5 clk_sys = ~clk_sys;

	always @(posedge clk_sys) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= TIMEOUT_CYCLES)
			stop_run($sformatf("Timeout: the run did not end within %0d cycles", TIMEOUT_CYCLES));
	end

	////////////////////
	// Compare tasks
	task automatic stop_run(input string why);
		$display("%s", why);
		$display("*** TEST FAILED ***");
		$fatal(1, "Stopping on the first error");
	endtask

	task automatic check_boot(input string name, input boot_wr_t exp, input boot_wr_t act);
		logic bad;
		bad = act.wr !== exp.wr;
		if (exp.wr) // Address only counts on a real write
			bad = bad || act.addr !== exp.addr || act.bank !== exp.bank || act.dout !== exp.dout;
		if (bad)
			stop_run($sformatf("[ERROR] %s: expected wr %b addr %h bank %h dout %h, %s",
				name, exp.wr, exp.addr, exp.bank, exp.dout,
				$sformatf("actual wr %b addr %h bank %h dout %h",
					act.wr, act.addr, act.bank, act.dout)));
	endtask

	task automatic check_map(input string name, input logic [MAP_PAGES-1:0] exp,
		input logic [MAP_PAGES-1:0] act);
		if (act !== exp)
			stop_run($sformatf("[ERROR] %s: expected %h, actual %h", name, exp, act));
	endtask

	task automatic check_bit(input string name, input logic exp, input logic act);
		if (act !== exp)
			stop_run($sformatf("[ERROR] %s: expected %b, actual %b", name, exp, act));
	endtask

	task automatic check_byte(input string name, input logic [7:0] exp, input logic [7:0] act);
		if (act !== exp)
			stop_run($sformatf("[ERROR] %s: expected %h, actual %h", name, exp, act));
	endtask

	////////////////////
	// Stimulus tasks
	task automatic next_edge();
		@(posedge clk_sys);
		#1; // Inputs change just after the edge
	endtask

	task automatic start_download(input logic [7:0] index, input logic [15:0] ext);
		next_edge();
		ioctl.download = 1'b0;
		next_edge();
		ioctl.index    = index;
		ioctl.file_ext = ext;
		ioctl.download = 1'b1;
		next_edge();
		next_edge(); // Page settled
	endtask

	// One byte, then wr falls with the address held
	task automatic write_byte(input string name, input logic [24:0] addr, input boot_wr_t exp);
		next_edge();
		ioctl.addr = addr;
		ioctl.dout = exp.dout;
		ioctl.wr   = 1'b1;
		#2;
		check_boot(name, exp, boot);
		next_edge();
		ioctl.wr = 1'b0;
		next_edge();
		if (exp.wr && exp.addr[22])
			exp_map[exp.addr[21:14]] = 1'b1;
		check_map({name, " map"}, exp_map, rom_map);
	endtask

	task automatic pulse_strobe(input op_e op, input mf2_mode_e mode, input logic [15:0] addr,
		input logic [7:0] data);
		next_edge();
		mf2_mode = mode;
		if (op == OP_KEY) begin
			key_nmi = 1'b1;
		end else begin
			bus.addr  = addr;
			bus.dout  = data;
			bus.m1    = op == OP_M1;
			bus.io_wr = op == OP_IOW;
		end
		next_edge();
		key_nmi   = 1'b0;
		bus.m1    = 1'b0;
		bus.io_wr = 1'b0;
		next_edge();
	endtask

	task automatic read_ram(input string name, input logic [MF2_ADDR_W-1:0] store,
		input logic [7:0] exp, input logic paged);
		next_edge();
		bus.addr   = {3'b001, store}; // RAM window
		bus.mem_rd = 1'b1;
		next_edge();
		next_edge();
		check_bit({name, " ram_en"}, paged, ram_en);
		check_bit({name, " rom_en"}, 1'b0, rom_en);
		check_byte(name, exp, mf2_dout);
		bus.mem_rd = 1'b0;
		#1;
		check_byte({name, " idle"}, 8'hFF, mf2_dout);
	endtask

	////////////////////
	// Main sequence
	initial begin
		boot_wr_t    exp;
		logic [13:0] offset;
		logic [7:0]  data;
		ioctl    = '0;
		cpc664   = 1'b1;
		bus      = '0;
		key_nmi  = 1'b0;
		mf2_mode = MF2_ENABLED;
		reset    = 1'b1;
		exp_map  = '0;
		seed     = 37;
		repeat (4) @(posedge clk_sys);
		#1;
		reset = 1'b0;
		next_edge();
		check_map("after reset", '0, rom_map);
		check_bit("after reset nmi", 1'b0, mf2_nmi);
		check_bit("after reset en", 1'b0, mf2_en);

		// ROM download over the region table
		start_download(IDX_ROM, 16'h0000);
		for (int i = 0; i < N_ROM; i++) begin
			offset   = 14'($random(seed));
			exp.wr   = ROM_ROWS[i].wr;
			exp.addr = {ROM_ROWS[i].page, offset};
			exp.bank = ROM_ROWS[i].bank;
			exp.dout = 8'($random(seed));
			write_byte($sformatf("rom block %0d", ROM_ROWS[i].block),
				{ROM_ROWS[i].block, offset}, exp);
		end

		// Expansion pages from the file extension
		for (int i = 0; i < N_EXT; i++) begin
			start_download(IDX_EXT, EXT_ROWS[i].ext);
			offset   = 14'($random(seed));
			exp.wr   = 1'b1;
			exp.addr = {EXT_ROWS[i].page[8], EXT_ROWS[i].page[7:0] + EXT_ROWS[i].block, offset};
			exp.bank = {1'b0, cpc664}; // Model latched in reset
			exp.dout = 8'($random(seed));
			write_byte($sformatf("ext %s", EXT_ROWS[i].ext), {3'b000, EXT_ROWS[i].block, offset},
				exp);
		end

		// Z0 runs on into page 1FF after its last byte
		start_download(IDX_EXT, "Z0");
		exp.wr   = 1'b1;
		exp.addr = {9'h000, 14'h3FFF};
		exp.bank = {1'b0, cpc664};
		exp.dout = 8'($random(seed));
		write_byte("combo last byte", {11'd0, 14'h3FFF}, exp);
		offset   = 14'($random(seed));
		exp.addr = {9'h1FF, offset};
		exp.dout = 8'($random(seed));
		write_byte("combo next page", {11'd0, offset}, exp);
		next_edge();
		ioctl.download = 1'b0;

		// MF2 paging
		for (int i = 0; i < N_MF2; i++) begin
			pulse_strobe(MF2_ROWS[i].op, MF2_ROWS[i].mode, MF2_ROWS[i].addr, 8'h00);
			check_bit($sformatf("mf2 row %0d nmi", i), MF2_ROWS[i].nmi, mf2_nmi);
			check_bit($sformatf("mf2 row %0d en", i), MF2_ROWS[i].en, mf2_en);
		end

		////////////////////
		// Register shadowing while paged out
		for (int i = 0; i < N_SHADOW; i++) begin
			data = SHADOW_ROWS[i].rnd ? 8'($random(seed)) : SHADOW_ROWS[i].data;
			pulse_strobe(OP_IOW, MF2_ENABLED, {SHADOW_ROWS[i].port, 8'h00}, data);
			exp_ram[SHADOW_ROWS[i].store] = data;
			check_byte($sformatf("shadow %h no read", SHADOW_ROWS[i].port), 8'hFF, mf2_dout);
		end
		read_ram("read while paged out", 13'h1FCF, 8'hFF, 1'b0);

		pulse_strobe(OP_KEY, MF2_ENABLED, 16'h0000, 8'h00);
		pulse_strobe(OP_M1, MF2_ENABLED, 16'h0066, 8'h00);
		check_bit("page in en", 1'b1, mf2_en);
		check_bit("page in rom_en", 1'b1, rom_en); // Address still on the NMI vector
		check_bit("page in ram_en", 1'b0, ram_en);
		for (int i = 0; i < N_SHADOW; i++)
			read_ram($sformatf("store %h", SHADOW_ROWS[i].store), SHADOW_ROWS[i].store,
				exp_ram[SHADOW_ROWS[i].store], 1'b1);

		$display("*** TEST PASSED ***");
		$finish;
	end

endmodule

//--- project.f
+incdir+test
source/cpc_boot_pkg.sv
source/mf2_pkg.sv
source/page_config.sv
source/rom_loader.sv
source/mf2_control.sv
source/mf2_shadow.sv
source/cpc_expansion_top.sv
test/tb_cpc_expansion.sv

//--- run_sim.sh
#!/bin/sh
# Compile with Verilator and run, the exit status is the simulator's
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal \
	-f project.f \
	--top-module tb_cpc_expansion

./obj_dir/Vtb_cpc_expansion
